// File: source/dacPkg.sv
`default_nettype none

package dacPkg;

    // widths with a meaning of their own
    typedef logic signed [11:0] dacSample_t;
    typedef logic [15:0] spiWord_t;
    typedef logic [1:0] regAddr_t;
    typedef logic [15:0] regData_t;
    typedef logic [15:0] rateDiv_t;
    typedef logic [3:0] fifoCount_t;

    // serializer states
    typedef enum logic [1:0] {
        DAC_IDLE  = 2'b00,
        DAC_START = 2'b01,
        DAC_SHIFT = 2'b11
    } dacState_t;

    // register map
    localparam regAddr_t ADDR_CONTROL = 2'd0;
    localparam regAddr_t ADDR_RATE = 2'd1;
    localparam regAddr_t ADDR_SAMPLE = 2'd2;
    localparam regAddr_t ADDR_STATUS = 2'd3;

    localparam int FIFO_DEPTH = 8;

    // spiClk is clk divided by 2**SPI_DIV_BITS
    localparam int SPI_DIV_BITS = 4;
    localparam int FRAME_BITS = 16;

endpackage

`default_nettype wire

// File: source/dacRegisters.sv
`timescale 1ns/1ns
`default_nettype none

module dacRegisters (
    input  logic              clk,
    input  logic              reset,
    input  dacPkg::regAddr_t  regAddr,
    input  dacPkg::regData_t  regWriteData,
    input  logic              regWrite,
    input  logic              regRead,
    input  logic              pushReady,
    input  dacPkg::fifoCount_t fifoCount,
    input  logic              busy,
    output logic              regReady,
    output dacPkg::regData_t  regReadData,
    output logic              pushValid,
    output dacPkg::dacSample_t pushData,
    output logic              enable,
    output dacPkg::rateDiv_t  rateDiv
);
    import dacPkg::*;

    logic     writeDone;
    logic     fifoFull;
    logic     fifoEmpty;
    regData_t statusWord;
    regData_t readMux;

    // only a sample write can stall, and only on a full FIFO
    assign regReady = (regAddr != ADDR_SAMPLE) || pushReady;
    assign writeDone = regWrite && regReady;

    assign pushValid = regWrite && (regAddr == ADDR_SAMPLE);
    assign pushData = regWriteData[11:0];

    assign fifoFull = (fifoCount == fifoCount_t'(FIFO_DEPTH));
    assign fifoEmpty = (fifoCount == '0);
    assign statusWord = {9'd0, busy, fifoFull, fifoEmpty, fifoCount};

    always_ff @(posedge clk) begin
        if (reset) begin
            enable <= 1'b0;
            rateDiv <= '0;
        end else if (writeDone) begin
            if (regAddr == ADDR_CONTROL) begin
                enable <= regWriteData[0];
            end
            if (regAddr == ADDR_RATE) begin
                rateDiv <= regWriteData;
            end
        end
    end

    always_comb begin
        case (regAddr)
            ADDR_CONTROL: readMux = {15'd0, enable};
            ADDR_RATE:    readMux = rateDiv;
            ADDR_STATUS:  readMux = statusWord;
            // sample register is write only
            default:      readMux = '0;
        endcase
    end

    // read data holds until the next read pulse
    always_ff @(posedge clk) begin
        if (regRead) begin
            regReadData <= readMux;
        end
    end

endmodule

`default_nettype wire

// File: source/sampleFifo.sv
`timescale 1ns/1ns
`default_nettype none

module sampleFifo (
    input  logic               clk,
    input  logic               reset,
    input  logic               pushValid,
    input  dacPkg::dacSample_t pushData,
    input  logic               fifoReady,
    output logic               pushReady,
    output logic               fifoValid,
    output dacPkg::dacSample_t fifoData,
    output dacPkg::fifoCount_t fifoCount
);
    import dacPkg::*;

    localparam int PTR_BITS = $clog2(FIFO_DEPTH);

    dacSample_t          mem [FIFO_DEPTH];
    logic [PTR_BITS-1:0] wrPtr;
    logic [PTR_BITS-1:0] rdPtr;
    logic                full;
    logic                empty;
    logic                doPush;
    logic                doPop;

    assign full = (fifoCount == fifoCount_t'(FIFO_DEPTH));
    assign empty = (fifoCount == '0);

    assign pushReady = !full;
    assign fifoValid = !empty;
    assign fifoData = mem[rdPtr];

    assign doPush = pushValid && pushReady;
    assign doPop = fifoValid && fifoReady;

    always_ff @(posedge clk) begin
        if (doPush) begin
            mem[wrPtr] <= pushData;
        end
    end

    // pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk) begin
        if (reset) begin
            wrPtr <= '0;
            rdPtr <= '0;
            fifoCount <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({doPush, doPop})
                2'b10:   fifoCount <= fifoCount + 1'b1;
                2'b01:   fifoCount <= fifoCount - 1'b1;
                default: fifoCount <= fifoCount;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/samplePacer.sv
`timescale 1ns/1ns
`default_nettype none

module samplePacer (
    input  logic               clk,
    input  logic               reset,
    input  logic               enable,
    input  dacPkg::rateDiv_t   rateDiv,
    input  logic               fifoValid,
    input  dacPkg::dacSample_t fifoData,
    input  logic               sampleReady,
    output logic               fifoReady,
    output logic               sampleValid,
    output dacPkg::dacSample_t sampleData
);
    import dacPkg::*;

    rateDiv_t periodCount;
    logic     token;
    logic     releaseNow;
    logic     moved;

    // enable is also gated here so a cleared enable stops releases at once
    assign releaseNow = token && enable;

    assign sampleValid = releaseNow && fifoValid;
    assign fifoReady = releaseNow && sampleReady;
    assign sampleData = fifoData;
    assign moved = sampleValid && sampleReady;

    // the period restarts after each release, so transfers stay rateDiv+1 apart
    always_ff @(posedge clk) begin
        if (reset || !enable) begin
            periodCount <= '0;
            token <= 1'b0;
        end else if (token) begin
            if (moved) begin
                token <= 1'b0;
            end
        end else if (periodCount >= rateDiv) begin
            periodCount <= '0;
            token <= 1'b1;
        end else begin
            periodCount <= periodCount + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: source/max5352Interface.sv
`timescale 1ns/1ns
`default_nettype none

module max5352Interface (
    input  logic               clk,
    input  logic               reset,
    input  logic               sampleValid,
    input  dacPkg::dacSample_t sampleData,
    output logic               sampleReady,
    output logic               busy,
    output logic               spiDout,
    output logic               spiClk,
    output logic               spiCsn
);
    import dacPkg::*;

    localparam int BIT_INDEX_BITS = $clog2(FRAME_BITS);

    typedef logic [BIT_INDEX_BITS-1:0] bitIndex_t;

    logic [SPI_DIV_BITS-1:0] clkCount;
    logic                    clkWrap;
    dacState_t               dacState;
    bitIndex_t               bitCount;
    spiWord_t                shiftReg;
    spiWord_t                frameWord;

    // free-running divider; the wrap is the falling edge of spiClk
    always_ff @(posedge clk) begin
        if (reset) begin
            clkCount <= '0;
        end else begin
            clkCount <= clkCount + 1'b1;
        end
    end

    assign spiClk = clkCount[SPI_DIV_BITS-1];
    assign clkWrap = &clkCount;

    // three zero control bits, offset binary sample, one trailing zero
    assign frameWord = {3'b000, ~sampleData[11], sampleData[10:0], 1'b0};

    assign sampleReady = (dacState == DAC_IDLE);
    assign busy = (dacState != DAC_IDLE);
    assign spiDout = shiftReg[FRAME_BITS-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            dacState <= DAC_IDLE;
            spiCsn <= 1'b1;
            bitCount <= '0;
        end else begin
            case (dacState)
                DAC_IDLE: begin
                    if (sampleValid) begin
                        shiftReg <= frameWord;
                        dacState <= DAC_START;
                    end
                end
                DAC_START: begin
                    if (clkWrap) begin
                        spiCsn <= 1'b0;
                        bitCount <= bitIndex_t'(FRAME_BITS - 1);
                        dacState <= DAC_SHIFT;
                    end
                end
                DAC_SHIFT: begin
                    // data moves only on the wrap, clear of the rising edge
                    if (clkWrap) begin
                        if (bitCount == '0) begin
                            spiCsn <= 1'b1;
                            dacState <= DAC_IDLE;
                        end else begin
                            shiftReg <= {shiftReg[FRAME_BITS-2:0], 1'b0};
                            bitCount <= bitCount - 1'b1;
                        end
                    end
                end
                default: begin
                    spiCsn <= 1'b1;
                    dacState <= DAC_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/dacChannel.sv
`timescale 1ns/1ns
`default_nettype none

module dacChannel (
    input  logic             clk,
    input  logic             reset,
    input  dacPkg::regAddr_t regAddr,
    input  dacPkg::regData_t regWriteData,
    input  logic             regWrite,
    input  logic             regRead,
    output logic             regReady,
    output dacPkg::regData_t regReadData,
    output logic             spiDout,
    output logic             spiClk,
    output logic             spiCsn
);
    import dacPkg::*;

    logic       pushValid;
    logic       pushReady;
    dacSample_t pushData;
    logic       fifoValid;
    logic       fifoReady;
    dacSample_t fifoData;
    fifoCount_t fifoCount;
    logic       sampleValid;
    logic       sampleReady;
    dacSample_t sampleData;
    logic       enable;
    rateDiv_t   rateDiv;
    logic       busy;

    dacRegisters u_registers (
        .clk(clk), .reset(reset),
        .regAddr(regAddr), .regWriteData(regWriteData),
        .regWrite(regWrite), .regRead(regRead),
        .pushReady(pushReady), .fifoCount(fifoCount), .busy(busy),
        .regReady(regReady), .regReadData(regReadData),
        .pushValid(pushValid), .pushData(pushData),
        .enable(enable), .rateDiv(rateDiv)
    );

    sampleFifo u_fifo (
        .clk(clk), .reset(reset),
        .pushValid(pushValid), .pushData(pushData), .fifoReady(fifoReady),
        .pushReady(pushReady), .fifoValid(fifoValid),
        .fifoData(fifoData), .fifoCount(fifoCount)
    );

    samplePacer u_pacer (
        .clk(clk), .reset(reset),
        .enable(enable), .rateDiv(rateDiv),
        .fifoValid(fifoValid), .fifoData(fifoData), .sampleReady(sampleReady),
        .fifoReady(fifoReady), .sampleValid(sampleValid), .sampleData(sampleData)
    );

    max5352Interface u_serializer (
        .clk(clk), .reset(reset),
        .sampleValid(sampleValid), .sampleData(sampleData),
        .sampleReady(sampleReady), .busy(busy),
        .spiDout(spiDout), .spiClk(spiClk), .spiCsn(spiCsn)
    );

endmodule

`default_nettype wire

// File: sim/spiFrameChecker.sv
`timescale 1ns/1ns
`default_nettype none

module spiFrameChecker (
    input logic              clk,
    input logic              reset,
    input dacPkg::regAddr_t  regAddr,
    input dacPkg::regData_t  regWriteData,
    input logic              regWrite,
    input logic              regRead,
    input logic              regReady,
    input dacPkg::regData_t  regReadData,
    input logic              spiDout,
    input logic              spiClk,
    input logic              spiCsn,
    input logic              checkRead,
    input dacPkg::regData_t  readExpect,
    input logic              statusFromQueue,
    input logic              expectBlocked,
    input logic              endOfRun
);
    import dacPkg::*;

    spiWord_t expectQueue[$];
    spiWord_t shiftIn = '0;
    regData_t readWant;
    regData_t heldData = '0;
    int       errorCount = 0;
    int       frameCount = 0;
    int       bitCount = 0;
    int       rate = 0;
    longint   cycle = 0;
    longint   lastFall = 0;
    logic     haveFall = 1'b0;
    logic     prevCsn = 1'b1;
    logic     prevSpiClk = 1'b0;
    logic     prevRead = 1'b0;
    logic     readSeen = 1'b0;

    // offset binary is the sample plus half scale, left of one trailing zero
    function automatic spiWord_t frameOf(input regData_t data);
        logic [11:0] offset;
        offset = data[11:0] + 12'd2048;
        return {3'b000, offset, 1'b0};
    endfunction

    task automatic compareValue(input string name, input logic [15:0] want,
                                input logic [15:0] got);
        if (got !== want) begin
            $display("ERR %0t %s expected %h actual %h", $time, name, want, got);
            errorCount++;
        end
    endtask

    always @(negedge reset) begin
        compareValue("spiCsn", 16'd1, {15'd0, spiCsn});
        compareValue("spiClk", 16'd0, {15'd0, spiClk});
        compareValue("regReady", 16'd1, {15'd0, regReady});
    end

    always @(posedge clk) begin
        if (!reset) begin
            cycle++;
            if (regWrite && regReady) begin
                if (regAddr == ADDR_SAMPLE) begin
                    expectQueue.push_back(frameOf(regWriteData));
                end
                if (regAddr == ADDR_RATE) begin
                    rate = int'(regWriteData);
                    haveFall = 1'b0;
                end
                if (expectBlocked) begin
                    $display("at %0t a sample write went through on a full FIFO", $time);
                    errorCount++;
                end
            end
            if (checkRead) begin
                // status with nothing in flight follows from the samples still queued
                readWant = statusFromQueue ? regData_t'(expectQueue.size()) : readExpect;
                if (statusFromQueue) begin
                    readWant[4] = (expectQueue.size() == 0);
                    readWant[5] = (expectQueue.size() == FIFO_DEPTH);
                end
                compareValue("regReadData", readWant, regReadData);
            end
            // read data may only change on the cycle after a read pulse
            if (prevRead) begin
                readSeen = 1'b1;
            end else if (readSeen) begin
                compareValue("regReadData", heldData, regReadData);
            end
            heldData = regReadData;
            prevRead = regRead;
            if (prevCsn && !spiCsn) begin
                // a fall lands up to one spiClk period after the sample was accepted
                if (haveFall && cycle - lastFall < rate + 1 - ((1 << SPI_DIV_BITS) - 1)) begin
                    $display("at %0t frame began %0d cycles after the previous one at rate %0d",
                             $time, cycle - lastFall, rate);
                    errorCount++;
                end
                haveFall = 1'b1;
                lastFall = cycle;
                bitCount = 0;
            end
            if (!spiCsn && spiClk && !prevSpiClk) begin
                shiftIn = {shiftIn[FRAME_BITS-2:0], spiDout};
                bitCount++;
            end
            if (!prevCsn && spiCsn) begin
                frameCount++;
                if (bitCount != FRAME_BITS) begin
                    $display("at %0t frame had %0d spiClk edges instead of %0d", $time,
                             bitCount, FRAME_BITS);
                    errorCount++;
                end
                if (expectQueue.size() == 0) begin
                    $display("at %0t frame %h came out with no sample written for it", $time,
                             shiftIn);
                    errorCount++;
                end else begin
                    compareValue("spiDout frame", expectQueue.pop_front(), shiftIn);
                end
            end
            if (endOfRun && expectQueue.size() != 0) begin
                $display("%0d written samples never came out on SPI", expectQueue.size());
                errorCount++;
                expectQueue.delete();
            end
            prevCsn = spiCsn;
            prevSpiClk = spiClk;
        end
    end

endmodule

`default_nettype wire

// File: sim/dacChannelTb.sv
`timescale 1ns/1ns
`default_nettype none

module dacChannelTb;
    import dacPkg::*;

    logic     clk;
    logic     reset;
    regAddr_t regAddr;
    regData_t regWriteData;
    logic     regWrite;
    logic     regRead;
    logic     regReady;
    regData_t regReadData;
    logic     spiDout;
    logic     spiClk;
    logic     spiCsn;
    logic     checkRead;
    regData_t readExpect;
    logic     statusFromQueue;
    logic     expectBlocked;
    logic     endOfRun;
    logic     traceOk;

    // one entry per trace command
    byte      opQ[$];
    int       argA[$];
    int       argB[$];
    int       argC[$];
    string    nameQ[$];

    logic [15:0] lfsrState = 16'd98;
    longint      cycleCount = 0;
    longint      cycleLimit = 0;
    string       testName = "";
    int          errorsAtStart = 0;
    int          testCount = 0;
    int          failedCount = 0;

    dacChannel u_dut (
        .clk(clk), .reset(reset),
        .regAddr(regAddr), .regWriteData(regWriteData),
        .regWrite(regWrite), .regRead(regRead),
        .regReady(regReady), .regReadData(regReadData),
        .spiDout(spiDout), .spiClk(spiClk), .spiCsn(spiCsn)
    );

    spiFrameChecker u_checker (
        .clk(clk), .reset(reset),
        .regAddr(regAddr), .regWriteData(regWriteData),
        .regWrite(regWrite), .regRead(regRead),
        .regReady(regReady), .regReadData(regReadData),
        .spiDout(spiDout), .spiClk(spiClk), .spiCsn(spiCsn),
        .checkRead(checkRead), .readExpect(readExpect),
        .statusFromQueue(statusFromQueue), .expectBlocked(expectBlocked),
        .endOfRun(endOfRun)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleLimit != 0 && cycleCount > cycleLimit) begin
            $display("timeout: trace still running after %0d cycles", cycleCount);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // galois step, taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] nextLfsr(input logic [15:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 16'hB400;
        end
        return state >> 1;
    endfunction

    function automatic logic [11:0] randomSample();
        logic [11:0] value;
        value = '0;
        for (int k = 0; k < 12; k++) begin
            value = {value[10:0], lfsrState[0]};
            lfsrState = nextLfsr(lfsrState);
        end
        return value;
    endfunction

    task automatic readTrace(output logic ok);
        int     fd;
        string  line;
        string  word;
        string  name;
        byte    op;
        int     a;
        int     b;
        int     c;
        int     badLines;
        longint waits;
        longint samples;
        longint maxRate;
        badLines = 0;
        waits = 0;
        samples = 0;
        maxRate = 0;
        fd = $fopen("sim/dacTrace.txt", "r");
        ok = (fd != 0);
        while (ok && $fgets(line, fd) != 0) begin
            op = line.getc(0);
            if (op == "#" || op == "\n" || op == "\r" || op == 0) begin
                continue;
            end
            a = 0;
            b = 0;
            c = 0;
            name = "";
            case (op)
                "T": void'($sscanf(line, "%s %s", word, name));
                "D", "L": void'($sscanf(line, "%s %d", word, a));
                "W", "B", "R", "S": void'($sscanf(line, "%s %h %h %d", word, a, b, c));
                default: begin
                    $display("unknown trace command in line %s", line);
                    badLines++;
                end
            endcase
            opQ.push_back(op);
            argA.push_back(a);
            argB.push_back(b);
            argC.push_back(c);
            nameQ.push_back(name);
            if (op == "D") begin
                waits += a;
            end
            if (op == "L") begin
                samples += a;
            end
            if ((op == "W" || op == "B") && a == int'(ADDR_SAMPLE)) begin
                samples++;
            end
            if (op == "W" && a == int'(ADDR_RATE) && b > maxRate) begin
                maxRate = b;
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        ok = ok && (badLines == 0);
        // worst case per sample is a whole frame, one pacer period and the csn latency
        cycleLimit = waits + samples * (16 * 18 + maxRate + 16) + 2000;
    endtask

    task automatic writeReg(input regAddr_t addr, input regData_t data);
        logic done;
        done = 1'b0;
        regAddr = addr;
        regWriteData = data;
        regWrite = 1'b1;
        while (!done) begin
            #1;
            done = regReady;
            @(negedge clk);
        end
        regWrite = 1'b0;
    endtask

    task automatic blockedWrite(input regAddr_t addr, input regData_t data, input int cycles);
        regAddr = addr;
        regWriteData = data;
        regWrite = 1'b1;
        expectBlocked = 1'b1;
        repeat (cycles) @(negedge clk);
        regWrite = 1'b0;
        expectBlocked = 1'b0;
    endtask

    task automatic readReg(input regAddr_t addr, input regData_t expected,
                           input logic fromQueue);
        regAddr = addr;
        regRead = 1'b1;
        @(negedge clk);
        regRead = 1'b0;
        checkRead = 1'b1;
        readExpect = expected;
        statusFromQueue = fromQueue;
        @(negedge clk);
        checkRead = 1'b0;
        statusFromQueue = 1'b0;
    endtask

    task automatic closeTest();
        int errs;
        if (testName != "") begin
            errs = u_checker.errorCount - errorsAtStart;
            testCount++;
            if (errs != 0) begin
                failedCount++;
            end
            $display("test %s %s with %0d errors", testName, (errs == 0) ? "passed" : "failed",
                     errs);
        end
    endtask

    task automatic runCommand(input int i);
        case (opQ[i])
            "T": begin
                closeTest();
                testName = nameQ[i];
                errorsAtStart = u_checker.errorCount;
            end
            "W": writeReg(regAddr_t'(argA[i]), regData_t'(argB[i]));
            "B": blockedWrite(regAddr_t'(argA[i]), regData_t'(argB[i]), argC[i]);
            "R": readReg(regAddr_t'(argA[i]), regData_t'(argB[i]), 1'b0);
            "S": readReg(ADDR_STATUS, '0, 1'b1);
            "L": repeat (argA[i]) writeReg(ADDR_SAMPLE, regData_t'(randomSample()));
            "D": repeat (argA[i]) @(negedge clk);
            default: ;
        endcase
    endtask

    initial begin
        reset = 1'b1;
        regAddr = '0;
        regWriteData = '0;
        regWrite = 1'b0;
        regRead = 1'b0;
        checkRead = 1'b0;
        readExpect = '0;
        statusFromQueue = 1'b0;
        expectBlocked = 1'b0;
        endOfRun = 1'b0;
        readTrace(traceOk);
        if (!traceOk) begin
            $display("trace file sim/dacTrace.txt could not be read");
            $display("ERRORS FOUND");
            $finish;
        end else begin
            repeat (3) @(posedge clk);
            @(negedge clk);
            reset = 1'b0;
            foreach (opQ[i]) begin
                runCommand(i);
            end
            // leftover expected frames count against the last test
            endOfRun = 1'b1;
            @(negedge clk);
            endOfRun = 1'b0;
            @(negedge clk);
            closeTest();
            $display("tests %0d, failed %0d, errors %0d, frames %0d", testCount, failedCount,
                     u_checker.errorCount, u_checker.frameCount);
            if (u_checker.errorCount == 0) begin
                $display("NO ERRORS");
            end else begin
                $display("ERRORS FOUND");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: sim/dacTrace.txt
# op a b c: W addr data, B addr data cycles (must stay blocked), R addr expect, S status check
# L count random samples, D cycles wait, T name opens a test; addr/data hex, counts decimal
T reset
R 3 0010
T single
W 0 0001
W 2 0000
W 2 07FF
W 2 0800
W 2 0FFF
D 1200
T fifo_full
W 0 0000
L 8
B 2 0909 10
R 3 0028
W 0 0001
W 2 0909
D 2600
S
T rate
W 1 0258
L 3
D 2200
S
T burst
W 1 0000
L 20
D 2600
R 3 0010
T disable
L 8
D 400
W 0 0000
D 600
S
T drain
W 0 0001
D 2000
R 3 0010

// File: filelist.f
source/dacPkg.sv
source/dacRegisters.sv
source/sampleFifo.sv
source/samplePacer.sv
source/max5352Interface.sv
source/dacChannel.sv
sim/spiFrameChecker.sv
sim/dacChannelTb.sv

// File: runSim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it from the project root and check the log
rm -f sim.log \
    && verilator --binary --timing --top-module dacChannelTb -f filelist.f -Mdir obj_dir -o dacSim \
    && ./obj_dir/dacSim | tee sim.log \
    && grep -qx "NO ERRORS" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
